//--- common/quiz_macros.svh
`ifndef QUIZ_MACROS_SVH
`define QUIZ_MACROS_SVH

// board size
`define QUIZ_SWITCHES 10
`define QUIZ_DIGITS 4

// game length
`define QUIZ_LEVELS 4

// 50 MHz board clock, two ticks a second
`define QUIZ_TICK_CYCLES 25000000

`endif

//--- common/quiz_pkg.sv
`include "quiz_macros.svh"

package quiz_pkg;

	typedef logic [`QUIZ_SWITCHES-1:0] switch_t; // switches and leds
	typedef logic [6:0] seg_t; // a..g on bits 6..0, active low
	typedef logic [$clog2(`QUIZ_LEVELS)-1:0] level_t; // 0 is level 1

	// digits keep their own value so a number casts straight in
	typedef enum logic [4:0] {
		g_0, g_1, g_2, g_3, g_4, g_5, g_6, g_7, g_8, g_9,
		g_blank,
		g_dash,
		g_t, g_r, g_u,
		g_f, g_a, g_l, g_s,
		g_e, g_n, g_d
	} glyph_t;

	// element 3 is the leftmost digit
	typedef glyph_t [`QUIZ_DIGITS-1:0] glyph_row_t;

	typedef enum logic [2:0] {
		state_start,
		state_chase,
		state_question,
		state_right_wait,
		state_wrong_wait,
		state_finish
	} game_state_t;

	// builds a row left to right, as it reads on the board
	function automatic glyph_row_t glyph_row(glyph_t g3, glyph_t g2, glyph_t g1, glyph_t g0);
		glyph_row_t row;
		row[3] = g3;
		row[2] = g2;
		row[1] = g1;
		row[0] = g0;
		return row;
	endfunction

endpackage

//--- src/tick_pacer.sv
`timescale 1ns/1ps
`include "quiz_macros.svh"

module tick_pacer #(
	parameter int TICK_CYCLES = `QUIZ_TICK_CYCLES
) (
	input  logic Clock,
	input  logic reset,
	output logic tick
);

	localparam int CW = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;
	localparam logic [CW-1:0] LAST = CW'(TICK_CYCLES - 1);

	logic [CW-1:0] count;

	always_ff @(posedge Clock or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else if (count == LAST) begin
			count <= '0; // wrap
		end else begin
			count <= count + 1'b1;
		end
	end

	// one clock wide, once per period
	assign tick = (count == LAST);

endmodule

//--- chaser/led_chaser.sv
`timescale 1ns/1ps
`include "quiz_macros.svh"

module led_chaser
	import quiz_pkg::*;
(
	input  logic    Clock,
	input  logic    reset,
	input  logic    tick,
	input  logic    chase,
	input  level_t  level,
	output switch_t led
);

	localparam int N = `QUIZ_SWITCHES;
	localparam logic [3:0] STEP_LAST = 4'(N - 1);

	logic [3:0] step;
	logic [3:0] step_next;
	switch_t up_mask; // lit at step 0, moving up
	switch_t down_mask; // lit at step 0, moving down
	logic [2*N-1:0] up_wide;
	logic [2*N-1:0] down_wide;
	switch_t pattern;

	always_comb begin
		step_next = step;
		if (tick) begin
			step_next = (step == STEP_LAST) ? 4'd0 : step + 1'b1;
		end
	end

	// start positions per level
	always_comb begin
		case (level)
			2'd0: begin
				up_mask = 10'h02A; // 1 3 5
				down_mask = 10'h000;
			end
			2'd1: begin
				up_mask = 10'h004; // 2
				down_mask = 10'h240; // 6 9
			end
			2'd2: begin
				up_mask = 10'h000;
				down_mask = 10'h110; // 4 8
			end
			default: begin
				up_mask = 10'h200; // 9
				down_mask = 10'h020; // 5
			end
		endcase
	end

	// doubled vector makes the shift a mod 10 rotate
	assign up_wide = {up_mask, up_mask} << step_next;
	assign down_wide = {down_mask, down_mask} >> step_next;
	assign pattern = up_wide[2*N-1:N] | down_wide[N-1:0];

	always_ff @(posedge Clock or posedge reset) begin
		if (reset) begin
			step <= '0;
			led <= '0;
		end else if (!chase) begin
			step <= '0; // restart on every level entry
			led <= '0;
		end else begin
			step <= step_next;
			led <= pattern;
		end
	end

endmodule

//--- game/answer_check.sv
`timescale 1ns/1ps

module answer_check
	import quiz_pkg::*;
(
	input  level_t     level,
	input  switch_t    switch,
	output glyph_row_t question,
	output logic       correct
);

	switch_t answer;

	// question digits and the binary answer the player must set
	always_comb begin
		case (level)
			2'd0: begin
				question = glyph_row(g_1, g_2, g_3, g_4); // 12 + 34
				answer = 10'd46;
			end
			2'd1: begin
				question = glyph_row(g_4, g_2, g_1, g_5); // 42 - 15
				answer = 10'd27;
			end
			2'd2: begin
				question = glyph_row(g_1, g_2, g_1, g_1); // 12 * 11
				answer = 10'd132;
			end
			default: begin
				question = glyph_row(g_9, g_8, g_0, g_7); // 98 / 7
				answer = 10'd14;
			end
		endcase
	end

	// full word compare, unused upper switches must be off too
	assign correct = (switch == answer);

endmodule

//--- game/game_control.sv
`timescale 1ns/1ps
`include "quiz_macros.svh"

module game_control
	import quiz_pkg::*;
(
	input  logic       Clock,
	input  logic       reset,
	input  logic       button,
	input  switch_t    switch,
	input  switch_t    led,
	input  glyph_row_t question,
	input  logic       correct,
	output level_t     level,
	output logic       chase,
	output glyph_row_t glyphs
);

	localparam int MW = $clog2(`QUIZ_SWITCHES + 1);
	localparam level_t LAST_LEVEL = level_t'(`QUIZ_LEVELS - 1);

	game_state_t state;
	game_state_t state_next;
	level_t level_next;
	logic button_q;
	logic press;
	logic all_off;
	logic caught;
	logic [MW-1:0] matched; // switches on under a lit led
	logic [MW-1:0] required;

	assign press = button & ~button_q; // rising edge only
	assign all_off = (switch == '0);

	always_comb begin
		matched = '0;
		for (int i = 0; i < `QUIZ_SWITCHES; i++) begin
			if (switch[i] && led[i]) begin
				matched = matched + 1'b1;
			end
		end
	end

	// three lit leds on the first two levels, two after that
	assign required = (level < 2'd2) ? MW'(3) : MW'(2);
	assign caught = (matched == required);

	always_comb begin
		state_next = state;
		level_next = level;
		case (state)
			state_start: begin
				if (press) begin
					state_next = state_chase;
					level_next = '0;
				end
			end
			state_chase: if (caught) state_next = state_question;
			state_question: begin
				if (press) begin
					state_next = correct ? state_right_wait : state_wrong_wait;
				end
			end
			state_right_wait: begin
				if (all_off) begin
					if (level == LAST_LEVEL) begin
						state_next = state_finish;
					end else begin
						state_next = state_chase;
						level_next = level + 1'b1;
					end
				end
			end
			state_wrong_wait: if (all_off) state_next = state_chase; // same level again
			state_finish: if (press) state_next = state_start;
			default: state_next = state_start;
		endcase
	end

	always_ff @(posedge Clock or posedge reset) begin
		if (reset) begin
			state <= state_start;
			level <= '0;
			button_q <= 1'b0;
		end else begin
			state <= state_next;
			level <= level_next;
			button_q <= button;
		end
	end

	assign chase = (state == state_chase);

	always_comb begin
		case (state)
			state_chase: glyphs = glyph_row(g_l, g_blank, g_blank, glyph_t'(5'(level) + 5'd1));
			state_question: glyphs = question;
			state_right_wait: glyphs = glyph_row(g_t, g_r, g_u, g_blank);
			state_wrong_wait: glyphs = glyph_row(g_f, g_a, g_l, g_s);
			state_finish: glyphs = glyph_row(g_e, g_n, g_d, g_blank);
			default: glyphs = glyph_row(g_dash, g_dash, g_dash, g_dash); // start screen
		endcase
	end

endmodule

//--- src/seg_display.sv
`timescale 1ns/1ps

module seg_display
	import quiz_pkg::*;
(
	input  logic       Clock,
	input  logic       reset,
	input  glyph_row_t glyphs,
	output seg_t       bcd0,
	output seg_t       bcd1,
	output seg_t       bcd2,
	output seg_t       bcd3
);

	localparam seg_t SEG_DASH = 7'b1111110;

	// abcdefg, a zero lights the segment
	function automatic seg_t seg_of(glyph_t g);
		case (g)
			g_0: return 7'b0000001;
			g_1: return 7'b1001111;
			g_2: return 7'b0010010;
			g_3: return 7'b0000110;
			g_4: return 7'b1001100;
			g_5: return 7'b0100100;
			g_6: return 7'b0100000;
			g_7: return 7'b0001111;
			g_8: return 7'b0000000;
			g_9: return 7'b0000100;
			g_dash: return SEG_DASH;
			g_t: return 7'b1110000;
			g_r: return 7'b1111010;
			g_u: return 7'b1100011;
			g_f: return 7'b0111000;
			g_a: return 7'b0001000;
			g_l: return 7'b1110001;
			g_s: return 7'b0100100; // same shape as 5
			g_e: return 7'b0110000;
			g_n: return 7'b1101010;
			g_d: return 7'b1000010;
			default: return 7'b1111111; // blank
		endcase
	endfunction

	always_ff @(posedge Clock or posedge reset) begin
		if (reset) begin
			bcd0 <= SEG_DASH;
			bcd1 <= SEG_DASH;
			bcd2 <= SEG_DASH;
			bcd3 <= SEG_DASH;
		end else begin
			bcd0 <= seg_of(glyphs[0]); // rightmost
			bcd1 <= seg_of(glyphs[1]);
			bcd2 <= seg_of(glyphs[2]);
			bcd3 <= seg_of(glyphs[3]);
		end
	end

endmodule

//--- src/quiz_top.sv
`timescale 1ns/1ps
`include "quiz_macros.svh"

module quiz_top
	import quiz_pkg::*;
#(
	parameter int TICK_CYCLES = `QUIZ_TICK_CYCLES
) (
	input  logic    Clock,
	input  logic    reset,
	input  logic    button,
	input  switch_t switch,
	output switch_t led,
	output seg_t    bcd0,
	output seg_t    bcd1,
	output seg_t    bcd2,
	output seg_t    bcd3
);

	logic tick;
	logic chase;
	logic correct;
	level_t level;
	glyph_row_t glyphs;
	glyph_row_t question;

	tick_pacer #(
		.TICK_CYCLES(TICK_CYCLES)
	) pacer0 (
		.Clock(Clock), .reset(reset), .tick(tick)
	);

	led_chaser chaser0 (
		.Clock(Clock), .reset(reset), .tick(tick),
		.chase(chase), .level(level), .led(led)
	);

	answer_check check0 (
		.level(level), .switch(switch), .question(question), .correct(correct)
	);

	game_control control0 (
		.Clock(Clock), .reset(reset), .button(button), .switch(switch),
		.led(led), .question(question), .correct(correct),
		.level(level), .chase(chase), .glyphs(glyphs)
	);

	seg_display display0 (
		.Clock(Clock), .reset(reset), .glyphs(glyphs),
		.bcd0(bcd0), .bcd1(bcd1), .bcd2(bcd2), .bcd3(bcd3)
	);

endmodule

//--- sim/quiz_tb.sv
`timescale 1ns/1ps
`include "quiz_macros.svh"

module quiz_tb
	import quiz_pkg::*;
();

	localparam int N = `QUIZ_SWITCHES;
	localparam int TIMEOUT = 200; // cycles per wait
	localparam int TICK = 6; // clocks per chaser step

	logic Clock;
	logic reset;
	logic button;
	switch_t switch;
	switch_t led;
	seg_t bcd0;
	seg_t bcd1;
	seg_t bcd2;
	seg_t bcd3;

	game_state_t exp_state; // model of the game
	int exp_level; // 0 is level 1
	int exp_step;
	int edges; // clock edges since reset went low
	int tries;
	int seed_ret;

	quiz_top #(.TICK_CYCLES(TICK)) dut0 (
		.Clock(Clock), .reset(reset), .button(button), .switch(switch),
		.led(led), .bcd0(bcd0), .bcd1(bcd1), .bcd2(bcd2), .bcd3(bcd3)
	);

	initial Clock = 1'b0;
	always #4 Clock = ~Clock;

	// tick lands on every TICK-th edge after reset
	always @(posedge Clock) begin
		if (reset) begin
			edges <= 0;
		end else begin
			edges <= edges + 1;
		end
	end

	// lit segments per character, a zero bit lights a segment
	function automatic seg_t seg_shape(byte ch);
		string lit;
		seg_t s;
		case (ch)
			"0": lit = "abcdef";
			"1": lit = "bc";
			"2": lit = "abdeg";
			"3": lit = "abcdg";
			"4": lit = "bcfg";
			"5": lit = "acdfg";
			"6": lit = "acdefg";
			"7": lit = "abc";
			"8": lit = "abcdefg";
			"9": lit = "abcdfg";
			"-": lit = "g";
			"t": lit = "defg";
			"r": lit = "eg";
			"u": lit = "cde";
			"F": lit = "aefg";
			"A": lit = "abcefg";
			"L": lit = "def";
			"S": lit = "acdfg";
			"E": lit = "adefg";
			"n": lit = "ceg";
			"d": lit = "bcdeg";
			default: lit = ""; // blank
		endcase
		s = 7'h7F;
		for (int i = 0; i < lit.len(); i++) begin
			s[int'("g") - int'(lit[i])] = 1'b0; // g is bit 0
		end
		return s;
	endfunction

	// one led that started at p, moving dir places per step
	function automatic switch_t lit_bit(int p, int dir, int k);
		return switch_t'(1) << ((p + dir * k + N) % N);
	endfunction

	function automatic switch_t led_rule(int lvl, int k);
		case (lvl)
			0: return lit_bit(1, 1, k) | lit_bit(3, 1, k) | lit_bit(5, 1, k);
			1: return lit_bit(2, 1, k) | lit_bit(6, -1, k) | lit_bit(9, -1, k);
			2: return lit_bit(4, -1, k) | lit_bit(8, -1, k);
			default: return lit_bit(9, 1, k) | lit_bit(5, -1, k);
		endcase
	endfunction

	// screen text, leftmost digit first
	function automatic string screen_of(game_state_t st, int lvl);
		case (st)
			state_chase: return $sformatf("L  %0d", lvl + 1);
			state_question: begin
				case (lvl)
					0: return "1234";
					1: return "4215";
					2: return "1211";
					default: return "9807";
				endcase
			end
			state_right_wait: return "tru ";
			state_wrong_wait: return "FALS";
			state_finish: return "End ";
			default: return "----";
		endcase
	endfunction

	function automatic switch_t answer_of(int lvl);
		case (lvl)
			0: return 10'd46;
			1: return 10'd27;
			2: return 10'd132;
			default: return 10'd14;
		endcase
	endfunction

	task automatic report_error(string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_led(switch_t got, switch_t exp);
		if (got !== exp) begin
			report_error($sformatf("Mismatch led: got %h, expected %h", got, exp));
		end
	endtask

	task automatic check_display(seg_t exp3, seg_t exp2, seg_t exp1, seg_t exp0);
		logic [3:0][6:0] got;
		logic [3:0][6:0] exp;
		got = {bcd3, bcd2, bcd1, bcd0};
		exp = {exp3, exp2, exp1, exp0};
		for (int i = 0; i < `QUIZ_DIGITS; i++) begin
			if (got[i] !== exp[i]) begin
				report_error($sformatf("Mismatch bcd%0d: got %h, expected %h", i, got[i], exp[i]));
			end
		end
	endtask

	// optionally waits for a new screen, then checks it against the model
	task automatic show_screen(logic moved);
		logic [27:0] old;
		string scr;
		int n;
		old = {bcd3, bcd2, bcd1, bcd0};
		n = 0;
		while (moved && {bcd3, bcd2, bcd1, bcd0} === old) begin
			if (n == TIMEOUT) report_error("Timeout: the display never changed");
			@(negedge Clock);
			n++;
		end
		scr = screen_of(exp_state, exp_level);
		check_display(seg_shape(scr[0]), seg_shape(scr[1]), seg_shape(scr[2]), seg_shape(scr[3]));
	endtask

	task automatic press_button();
		button = 1'b1;
		@(negedge Clock);
		button = 1'b0;
	endtask

	// next led pattern, entry means the level was just entered
	task automatic follow_led(logic entry);
		switch_t old;
		int n;
		old = entry ? '0 : led;
		n = 0;
		while (led === old) begin
			if (n == TIMEOUT) report_error("Timeout: the led pattern did not move");
			@(negedge Clock);
			n++;
		end
		if (entry)
			exp_step = (edges % TICK == 0) ? 1 : 0; // tick on the entry edge skips step 0
		else
			exp_step = (exp_step + 1) % N;
		check_led(led, led_rule(exp_level, exp_step));
	endtask

	task automatic play_level(logic right);
		switch_t guess;
		int n;
		n = 0;
		follow_led(1'b0);
		while ($countones(led) != ((exp_level < 2) ? 3 : 2)) begin
			if (n == 2 * N) report_error("Timeout: no pattern with enough lit leds");
			follow_led(1'b0);
			n++;
		end
		switch = led; // one switch under each lit led
		exp_state = state_question;
		show_screen(1'b1);
		guess = answer_of(exp_level);
		while (!right && (guess == answer_of(exp_level) || guess == '0)) begin
			guess = switch_t'($urandom);
		end
		switch = guess;
		press_button();
		exp_state = right ? state_right_wait : state_wrong_wait;
		show_screen(1'b1);
		switch = '0; // all off lets the game move on
		if (right) begin
			exp_level++;
		end
		exp_state = (exp_level == `QUIZ_LEVELS) ? state_finish : state_chase;
		show_screen(1'b1);
		if (exp_state == state_chase) begin
			follow_led(1'b1);
		end
	endtask

	initial begin
		seed_ret = $urandom(1635);
		reset = 1'b1;
		button = 1'b0;
		switch = '0;
		exp_state = state_start;
		exp_level = 0;
		exp_step = 0;
		tries = 0;
		repeat (10) @(posedge Clock);
		@(negedge Clock);
		reset = 1'b0;
		check_led(led, '0);
		show_screen(1'b0); // dashes out of reset

		press_button();
		exp_state = state_chase;
		show_screen(1'b1);
		follow_led(1'b1);
		for (int k = 0; k < N; k++) begin
			follow_led(1'b0); // full turn of level 1
		end

		// first answer always wrong, then random
		while (exp_level < `QUIZ_LEVELS) begin
			play_level(tries > 0 && $urandom % 3 != 0);
			tries++;
		end

		press_button();
		exp_state = state_start;
		show_screen(1'b1);
		check_led(led, '0);
		$display("Test passed");
		$finish;
	end

endmodule

//--- all.f
+incdir+common
common/quiz_pkg.sv
src/tick_pacer.sv
chaser/led_chaser.sv
game/answer_check.sv
game/game_control.sv
src/seg_display.sv
src/quiz_top.sv
sim/quiz_tb.sv
